// ==== hdl/saturn_alu_pkg.sv ====
package saturn_alu_pkg;

  // ALU operation codes
  typedef enum logic [3:0] {
    OP_ZERO     = 4'h0,
    OP_COPY     = 4'h1,
    OP_EXCH     = 4'h2,
    OP_2CMPL    = 4'h3,
    OP_ADD      = 4'h4,
    OP_CLR_MASK = 4'h5,
    OP_TEST_EQ  = 4'h6,
    OP_TEST_NEQ = 4'h7
  } alu_op_e;

  // working registers plus two pseudo sources
  typedef enum logic [2:0] {
    REG_A    = 3'd0,
    REG_B    = 3'd1,
    REG_C    = 3'd2,
    REG_D    = 3'd3,
    REG_IMM  = 3'd4,
    REG_ZERO = 3'd5
  } alu_reg_e;

  typedef logic [3:0]  nibble_t;
  typedef logic [3:0]  field_ptr_t;
  typedef logic [63:0] reg_word_t;

  typedef struct packed {
    alu_op_e    op;
    alu_reg_e   dest;
    alu_reg_e   src1;
    alu_reg_e   src2;
    field_ptr_t field_first;
    field_ptr_t field_last;
    nibble_t    imm;
  } alu_cmd_t;

  // enables are already gated by stall and run state
  typedef struct packed {
    logic       prep;
    logic       calc;
    logic       save;
    logic       first;
    field_ptr_t ptr;
  } alu_phase_t;

  typedef struct packed {
    nibble_t src1;
    nibble_t src2;
  } operand_pair_t;

  typedef struct packed {
    nibble_t res1;
    nibble_t res2;
    logic    carry;
    logic    is_zero;
  } alu_result_t;

endpackage

// ==== hdl/alu_control.sv ====
module alu_control (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_en_init,
  input  logic                       i_en_prep,
  input  logic                       i_en_calc,
  input  logic                       i_en_save,
  input  logic                       i_stalled,
  input  logic                       i_start,
  input  saturn_alu_pkg::alu_cmd_t   i_cmd,
  output saturn_alu_pkg::alu_cmd_t   o_cmd,
  output saturn_alu_pkg::alu_phase_t o_phase,
  output logic                       o_busy
);

  import saturn_alu_pkg::*;

  alu_cmd_t   cmd_q;
  field_ptr_t ptr_q;
  logic       run_q;
  logic       done_q;

  logic do_init;
  logic do_prep;
  logic do_calc;
  logic do_save;

  // strobes only count while the sequencer is not stalled
  assign do_init = !i_stalled && i_en_init && i_start && !run_q;
  assign do_prep = !i_stalled && i_en_prep && run_q;
  assign do_calc = !i_stalled && i_en_calc && run_q;
  assign do_save = !i_stalled && i_en_save && run_q;

  // command word held for the whole field
  always_ff @(posedge i_clk) begin
    if (do_init) begin
      cmd_q <= i_cmd;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      ptr_q  <= '0;
    end else begin
      if (do_init) begin
        run_q  <= 1'b1;
        done_q <= 1'b0;
        ptr_q  <= i_cmd.field_first;
      end
      if (do_prep) begin
        done_q <= 1'b0;
      end
      // last nibble of the field is known at calc
      if (do_calc) begin
        done_q <= (ptr_q == cmd_q.field_last);
      end
      if (do_save) begin
        // wraps from 15 back to 0
        ptr_q <= ptr_q + 4'd1;
        if (done_q) begin
          run_q  <= 1'b0;
          done_q <= 1'b0;
        end
      end
    end
  end

  assign o_cmd         = cmd_q;
  assign o_phase.prep  = do_prep;
  assign o_phase.calc  = do_calc;
  assign o_phase.save  = do_save;
  assign o_phase.first = (ptr_q == cmd_q.field_first);
  assign o_phase.ptr   = ptr_q;
  assign o_busy        = run_q;

endmodule

// ==== hdl/alu_nibble_unit.sv ====
module alu_nibble_unit (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  saturn_alu_pkg::alu_cmd_t      i_cmd,
  input  saturn_alu_pkg::alu_phase_t    i_phase,
  input  saturn_alu_pkg::operand_pair_t i_operands,
  output saturn_alu_pkg::alu_result_t   o_result
);

  import saturn_alu_pkg::*;

  operand_pair_t opnd_q;
  logic          carry_in_q;
  nibble_t       res1_q;
  nibble_t       res2_q;
  logic          carry_q;
  logic          is_zero_q;

  nibble_t    inv_src1;
  nibble_t    cmpl_nib;
  logic [4:0] sum;

  assign inv_src1 = ~opnd_q.src1;
  assign cmpl_nib = inv_src1 + {3'b000, carry_in_q};
  assign sum      = {1'b0, opnd_q.src1} + {1'b0, opnd_q.src2} + {4'b0000, carry_in_q};

  // prep latches operands and incoming carry
  always_ff @(posedge i_clk) begin
    if (i_phase.prep) begin
      opnd_q <= i_operands;
      case (i_cmd.op)
        OP_2CMPL, OP_TEST_EQ: carry_in_q <= i_phase.first ? 1'b1 : carry_q;
        OP_ADD, OP_TEST_NEQ:  carry_in_q <= i_phase.first ? 1'b0 : carry_q;
        default:              carry_in_q <= carry_q;
      endcase
    end
  end

  // result nibbles at calc
  always_ff @(posedge i_clk) begin
    if (i_phase.calc) begin
      case (i_cmd.op)
        OP_ZERO:     res1_q <= '0;
        OP_COPY:     res1_q <= opnd_q.src1;
        OP_EXCH: begin
          res1_q <= opnd_q.src2;
          res2_q <= opnd_q.src1;
        end
        OP_CLR_MASK: res1_q <= opnd_q.src1 & ~opnd_q.src2;
        OP_ADD:      res1_q <= sum[3:0];
        OP_2CMPL:    res1_q <= cmpl_nib;
        default:     res1_q <= res1_q;
      endcase
    end
  end

  // carry chain and zero tracking at calc
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      carry_q   <= 1'b0;
      is_zero_q <= 1'b0;
    end else if (i_phase.calc) begin
      case (i_cmd.op)
        OP_ADD: carry_q <= sum[4];
        OP_2CMPL: begin
          // borrow only ripples through an all-zero low part
          carry_q   <= (inv_src1 == 4'hf) && carry_in_q;
          is_zero_q <= (opnd_q.src1 == 4'h0) && (i_phase.first || is_zero_q);
        end
        OP_TEST_EQ:  carry_q <= (opnd_q.src1 == opnd_q.src2) && carry_in_q;
        OP_TEST_NEQ: carry_q <= (opnd_q.src1 != opnd_q.src2) || carry_in_q;
        default:     carry_q <= carry_q;
      endcase
    end
  end

  assign o_result.res1    = res1_q;
  assign o_result.res2    = res2_q;
  assign o_result.carry   = carry_q;
  assign o_result.is_zero = is_zero_q;

endmodule

// ==== hdl/alu_register_file.sv ====
module alu_register_file (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  saturn_alu_pkg::alu_cmd_t      i_cmd,
  input  saturn_alu_pkg::alu_phase_t    i_phase,
  input  saturn_alu_pkg::alu_result_t   i_result,
  output saturn_alu_pkg::operand_pair_t o_operands,
  input  saturn_alu_pkg::alu_reg_e      i_dump_sel,
  output saturn_alu_pkg::reg_word_t     o_dump_data,
  output logic                          o_carry
);

  import saturn_alu_pkg::*;

  // A, B, C, D indexed by the low bits of the register code
  reg_word_t regs [4];
  logic      carry_q;

  logic [5:0] nib_lsb;
  logic       writes_dest;

  assign nib_lsb     = {i_phase.ptr, 2'b00};
  assign writes_dest = i_cmd.op inside {OP_ZERO, OP_COPY, OP_EXCH,
                                        OP_2CMPL, OP_ADD, OP_CLR_MASK};

  function automatic logic is_gpr(alu_reg_e sel);
    return sel inside {REG_A, REG_B, REG_C, REG_D};
  endfunction

  // nibble at the current pointer with the immediate repeated at every position
  function automatic nibble_t pick_nibble(alu_reg_e sel);
    nibble_t nib;
    case (sel)
      REG_A, REG_B, REG_C, REG_D: nib = regs[sel[1:0]][nib_lsb +: 4];
      REG_IMM:                    nib = i_cmd.imm;
      default:                    nib = '0;
    endcase
    return nib;
  endfunction

  always_comb begin
    o_operands.src1 = pick_nibble(i_cmd.src1);
    o_operands.src2 = pick_nibble(i_cmd.src2);
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
      carry_q <= 1'b0;
    end else if (i_phase.save) begin
      if (writes_dest && is_gpr(i_cmd.dest)) begin
        regs[i_cmd.dest[1:0]][nib_lsb +: 4] <= i_result.res1;
      end
      // second half of an exchange
      if ((i_cmd.op == OP_EXCH) && is_gpr(i_cmd.src2)) begin
        regs[i_cmd.src2[1:0]][nib_lsb +: 4] <= i_result.res2;
      end
      case (i_cmd.op)
        OP_ADD, OP_TEST_EQ, OP_TEST_NEQ: carry_q <= i_result.carry;
        OP_2CMPL:                        carry_q <= !i_result.is_zero;
        default:                         carry_q <= carry_q;
      endcase
    end
  end

  always_comb begin
    case (i_dump_sel)
      REG_A, REG_B, REG_C, REG_D: o_dump_data = regs[i_dump_sel[1:0]];
      default:                    o_dump_data = '0;
    endcase
  end

  assign o_carry = carry_q;

endmodule

// ==== hdl/saturn_alu.sv ====
module saturn_alu (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_en_init,
  input  logic                      i_en_prep,
  input  logic                      i_en_calc,
  input  logic                      i_en_save,
  input  logic                      i_stalled,
  input  logic                      i_start,
  input  saturn_alu_pkg::alu_cmd_t  i_cmd,
  input  saturn_alu_pkg::alu_reg_e  i_dump_sel,
  output logic                      o_busy,
  output logic                      o_carry,
  output saturn_alu_pkg::reg_word_t o_dump_data
);

  import saturn_alu_pkg::*;

  alu_cmd_t      cmd;
  alu_phase_t    phase;
  operand_pair_t operands;
  alu_result_t   result;

  alu_control alu_control_inst (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_en_init (i_en_init),
    .i_en_prep (i_en_prep),
    .i_en_calc (i_en_calc),
    .i_en_save (i_en_save),
    .i_stalled (i_stalled),
    .i_start   (i_start),
    .i_cmd     (i_cmd),
    .o_cmd     (cmd),
    .o_phase   (phase),
    .o_busy    (o_busy)
  );

  alu_nibble_unit alu_nibble_unit_inst (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_cmd      (cmd),
    .i_phase    (phase),
    .i_operands (operands),
    .o_result   (result)
  );

  alu_register_file alu_register_file_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_cmd       (cmd),
    .i_phase     (phase),
    .i_result    (result),
    .o_operands  (operands),
    .i_dump_sel  (i_dump_sel),
    .o_dump_data (o_dump_data),
    .o_carry     (o_carry)
  );

endmodule

// ==== verification/tb_saturn_alu.sv ====
module tb_saturn_alu;
  timeunit 1ns;
  timeprecision 1ps;

  import saturn_alu_pkg::*;

  localparam int NUM_CMDS = 115;
  localparam logic [3:0] EN_INIT = 4'b1000;
  localparam logic [3:0] EN_PREP = 4'b0100;
  localparam logic [3:0] EN_CALC = 4'b0010;
  localparam logic [3:0] EN_SAVE = 4'b0001;

  logic      i_clk;
  logic      i_reset;
  logic      i_en_init;
  logic      i_en_prep;
  logic      i_en_calc;
  logic      i_en_save;
  logic      i_stalled;
  logic      i_start;
  alu_cmd_t  i_cmd;
  alu_reg_e  i_dump_sel;
  logic      o_busy;
  logic      o_carry;
  reg_word_t o_dump_data;

  // reference model state
  reg_word_t m_regs [4];
  logic      m_carry;
  logic      stall_on;
  int        checks;
  int        errors;

  saturn_alu saturn_alu_inst (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // at most 16 nibbles of 4 strobes per command and twice that for stalls
  initial begin
    #(NUM_CMDS * 16 * 4 * 100 * 2);
    $display("timeout: the run did not finish within the watchdog limit");
    $display("TEST FAILED");
    $finish;
  end

  // one strobe that is sometimes preceded by a stalled copy of itself
  task automatic pulse(input logic [3:0] en);
    if (stall_on && ($urandom % 3 == 0)) begin
      i_stalled = 1'b1;
      {i_en_init, i_en_prep, i_en_calc, i_en_save} = en;
      @(posedge i_clk);
      #10;
    end
    i_stalled = 1'b0;
    {i_en_init, i_en_prep, i_en_calc, i_en_save} = en;
    @(posedge i_clk);
    #10;
    {i_en_init, i_en_prep, i_en_calc, i_en_save} = 4'b0000;
  endtask

  function automatic int field_len(alu_cmd_t c);
    return int'(4'(c.field_last - c.field_first)) + 1;
  endfunction

  // field packed from its first nibble upward and wrapping past nibble 15
  function automatic reg_word_t gather(alu_reg_e sel, alu_cmd_t c);
    reg_word_t  v;
    field_ptr_t p;
    v = '0;
    for (int k = 0; k < field_len(c); k++) begin
      p = c.field_first + 4'(k);
      if (sel == REG_IMM) begin
        v[4*k +: 4] = c.imm;
      end else if (sel inside {REG_A, REG_B, REG_C, REG_D}) begin
        v[4*k +: 4] = m_regs[sel[1:0]][4*p +: 4];
      end
    end
    return v;
  endfunction

  task automatic scatter(alu_reg_e sel, alu_cmd_t c, reg_word_t v);
    field_ptr_t p;
    if (sel inside {REG_A, REG_B, REG_C, REG_D}) begin
      for (int k = 0; k < field_len(c); k++) begin
        p = c.field_first + 4'(k);
        m_regs[sel[1:0]][4*p +: 4] = v[4*k +: 4];
      end
    end
  endtask

  // whole-field arithmetic with the carry taken just above the field
  task automatic model_apply(alu_cmd_t c);
    reg_word_t   a;
    reg_word_t   b;
    logic [64:0] tot;
    int          bits;
    a = gather(c.src1, c);
    b = gather(c.src2, c);
    bits = 4 * field_len(c);
    case (c.op)
      OP_ZERO:     scatter(c.dest, c, '0);
      OP_COPY:     scatter(c.dest, c, a);
      OP_CLR_MASK: scatter(c.dest, c, a & ~b);
      OP_EXCH: begin
        scatter(c.dest, c, b);
        scatter(c.src2, c, a);
      end
      OP_ADD: begin
        tot = {1'b0, a} + {1'b0, b};
        scatter(c.dest, c, tot[63:0]);
        m_carry = tot[bits];
      end
      OP_2CMPL: begin
        tot = 65'd0 - {1'b0, a};
        scatter(c.dest, c, tot[63:0]);
        m_carry = (a != '0);
      end
      OP_TEST_EQ:  m_carry = (a == b);
      OP_TEST_NEQ: m_carry = (a != b);
      default: ;
    endcase
  endtask

  task automatic check_value(string name, reg_word_t exp, reg_word_t act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // the immediate and zero codes dump as zero
  task automatic check_state();
    reg_word_t want;
    for (int r = 0; r < 6; r++) begin
      i_dump_sel = alu_reg_e'(3'(r));
      want = '0;
      if (r < 4) begin
        want = m_regs[r];
      end
      #1;
      check_value($sformatf("o_dump_data(%s)", i_dump_sel.name()), want, o_dump_data);
    end
    check_value("o_carry", 64'(m_carry), 64'(o_carry));
    check_value("o_busy", 64'd0, 64'(o_busy));
  endtask

  // intrude puts a stray command on every init strobe while busy
  task automatic run_command(alu_cmd_t c, logic intrude);
    int rounds;
    i_cmd = c;
    i_start = 1'b1;
    pulse(EN_INIT);
    i_start = 1'b0;
    check_value("o_busy", 64'd1, 64'(o_busy));
    rounds = 0;
    while (o_busy && rounds < 20) begin
      if (rounds > 0) begin
        if (intrude) begin
          i_cmd = rand_cmd(alu_op_e'(4'($urandom % 8)), any_gpr(), any_src(), any_src());
          i_start = 1'b1;
        end
        pulse(EN_INIT);
        i_start = 1'b0;
      end
      pulse(EN_PREP);
      pulse(EN_CALC);
      pulse(EN_SAVE);
      rounds++;
    end
    if (o_busy) begin
      $display("error: o_busy still high after %0d nibble rounds", rounds);
      errors++;
    end
    model_apply(c);
    check_state();
  endtask

  function automatic alu_cmd_t rand_cmd(alu_op_e op, alu_reg_e dest, alu_reg_e s1,
                                        alu_reg_e s2);
    alu_cmd_t c;
    c.op = op;
    c.dest = dest;
    c.src1 = s1;
    c.src2 = s2;
    c.field_first = 4'($urandom);
    c.field_last = 4'($urandom);
    c.imm = 4'($urandom);
    return c;
  endfunction

  function automatic alu_reg_e any_src();
    return alu_reg_e'(3'($urandom % 6));
  endfunction

  function automatic alu_reg_e any_gpr();
    return alu_reg_e'(3'($urandom % 4));
  endfunction

  task automatic end_test(string name, int n, int err_before);
    $display("test %-22s %0d commands, %0d errors", name, n, errors - err_before);
  endtask

  initial begin
    alu_cmd_t c;
    alu_cmd_t cp;
    alu_reg_e r;
    int       e0;
    int       pick;
    void'($urandom(32'h4c68d780));
    i_reset = 1'b1;
    {i_en_init, i_en_prep, i_en_calc, i_en_save} = 4'b0000;
    i_stalled = 1'b0;
    i_start = 1'b0;
    i_cmd = '0;
    i_dump_sel = REG_A;
    stall_on = 1'b0;
    checks = 0;
    errors = 0;
    m_carry = 1'b0;
    m_regs = '{default: '0};
    repeat (2) @(posedge i_clk);
    #10;
    i_reset = 1'b0;

    e0 = errors;
    check_state();
    end_test("1 reset state", 0, e0);

    e0 = errors;
    for (int n = 0; n < 30; n++) begin
      pick = $urandom % 4;
      case (pick)
        0:       c = rand_cmd(OP_ZERO, any_gpr(), any_src(), any_src());
        1:       c = rand_cmd(OP_COPY, any_gpr(), any_src(), any_src());
        default: c = rand_cmd(OP_COPY, any_gpr(), REG_IMM, any_src());
      endcase
      run_command(c, 1'b0);
    end
    end_test("2 zero and copy", 30, e0);

    e0 = errors;
    for (int n = 0; n < 20; n++) begin
      run_command(rand_cmd(OP_ADD, any_gpr(), any_src(), any_src()), 1'b0);
    end
    end_test("3 add", 20, e0);

    e0 = errors;
    for (int n = 0; n < 20; n++) begin
      pick = $urandom % 3;
      r = any_gpr();
      case (pick)
        0:       c = rand_cmd(OP_2CMPL, any_gpr(), any_src(), any_src());
        1:       c = rand_cmd(OP_CLR_MASK, any_gpr(), any_src(), any_src());
        default: c = rand_cmd(OP_EXCH, r, r, any_gpr());
      endcase
      run_command(c, 1'b0);
    end
    end_test("4 cmpl, mask, exchange", 20, e0);

    // every other test compares against a fresh copy of its own source
    e0 = errors;
    for (int n = 0; n < 20; n++) begin
      c = rand_cmd(($urandom % 2 == 0) ? OP_TEST_EQ : OP_TEST_NEQ, any_gpr(), any_src(),
                   any_gpr());
      if (n % 2 == 0) begin
        cp = c;
        cp.op = OP_COPY;
        cp.dest = c.src2;
        run_command(cp, 1'b0);
      end
      run_command(c, 1'b0);
    end
    end_test("5 field tests", 30, e0);

    e0 = errors;
    stall_on = 1'b1;
    for (int n = 0; n < 15; n++) begin
      run_command(rand_cmd(alu_op_e'(4'($urandom % 8)), any_gpr(), any_src(), any_src()), 1'b1);
    end
    stall_on = 1'b0;
    end_test("6 stalls and busy init", 15, e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/alu_properties.sv ====
module alu_properties (
  input logic                       i_clk,
  input logic                       i_reset,
  input logic                       i_stalled,
  input saturn_alu_pkg::alu_phase_t o_phase,
  input logic                       o_busy
);
  timeunit 1ns;
  timeprecision 1ps;

  a_busy_low_after_reset: assert property (@(posedge i_clk) i_reset |=> !o_busy)
    else $error("o_busy high in the cycle after reset");

  a_single_enable: assert property (@(posedge i_clk)
      $onehot0({o_phase.prep, o_phase.calc, o_phase.save}))
    else $error("more than one phase enable active");

  // a stalled cycle leaves the field walk untouched
  a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
      i_stalled |=> $stable(o_phase.ptr) && $stable(o_busy))
    else $error("pointer or o_busy moved during a stall");

  a_busy_falls_on_save: assert property (@(posedge i_clk) disable iff (i_reset)
      $fell(o_busy) && !$past(i_reset) |-> $past(o_phase.save))
    else $error("o_busy fell without a save enable");

endmodule

bind alu_control alu_properties alu_properties_inst (
  .i_clk     (i_clk),
  .i_reset   (i_reset),
  .i_stalled (i_stalled),
  .o_phase   (o_phase),
  .o_busy    (o_busy)
);

// ==== flist.f ====
hdl/saturn_alu_pkg.sv
hdl/alu_control.sv
hdl/alu_nibble_unit.sv
hdl/alu_register_file.sv
hdl/saturn_alu.sv
verification/tb_saturn_alu.sv
verification/alu_properties.sv

// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_saturn_alu
	obj_dir/Vtb_saturn_alu > sim.log 2>&1; cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST PASSED" sim.log

obj_dir/Vtb_saturn_alu: flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module tb_saturn_alu -o Vtb_saturn_alu

clean:
	rm -rf obj_dir sim.log
